/* src/drp_macros.svh */
`ifndef DRP_MACROS_SVH
`define DRP_MACROS_SVH

`define DRP_ADDR_W     7        // MMCM DRP address width
`define DRP_DATA_W     16       // MMCM DRP data width
`define BYTECNT_W      7        // Register bus byte counter width

`define REG_DRP_ADDR   8'd0     // Bridge address / start, bit 7 = write
`define REG_DRP_DATA   8'd1     // Bridge write buffer and read word
`define REG_DRP_RESET  8'd2     // MMCM reset bit
`define REG_DRP_STATUS 8'd3     // Bridge busy / overrun
`define REG_STEP_ADDR  8'd4     // Stepper target word
`define REG_STEP_DELTA 8'd5     // Stepper signed delta
`define REG_STEP_CTRL  8'd6     // Stepper go / status

`define DRDY_LATENCY   2        // den to drdy, in clk_usb cycles (2 or more)
`define PHASE_W        6        // Phase field lives in bits 5:0

`endif

/* src/drp_pkg.sv */
`include "drp_macros.svh"

package drp_pkg;

  typedef logic [`DRP_ADDR_W-1:0] drp_addr_t;    // DRP word address
  typedef logic [`DRP_DATA_W-1:0] drp_word_t;    // DRP data word
  typedef logic [7:0]             reg_byte_t;    // Register bus byte
  typedef logic [`PHASE_W-1:0]    phase_t;       // Phase field of a word

  typedef enum logic [1:0] {
    BR_IDLE,                                     // Waiting for DRP_ADDR write
    BR_REQ,                                      // Req high, waiting for ack
    BR_DONE                                      // Req dropped, waiting for ack low
  } bridge_state_e;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_RD_REQ,                                   // Fetch the word
    ST_RD_REL,                                   // Release after read
    ST_WR_REQ,                                   // Write the stepped word
    ST_WR_REL                                    // Release after write
  } step_state_e;

  typedef enum logic [1:0] {
    AR_IDLE,                                     // Pick a requester
    AR_ISSUE,                                    // den pulse
    AR_WAIT,                                     // Wait for drdy
    AR_ACK                                       // Hold ack until req drops
  } arb_state_e;

endpackage

/* src/reg_drp_bridge.sv */
`include "drp_macros.svh"
`timescale 1ns/1ps

module reg_drp_bridge import drp_pkg::*; (
  input  logic                  clk_usb,
  input  logic                  reset_i,
  input  reg_byte_t             reg_address,
  input  logic [`BYTECNT_W-1:0] reg_bytecnt,
  input  reg_byte_t             reg_datai,
  input  logic                  reg_write,
  input  logic                  reg_read,
  output reg_byte_t             reg_datao,
  output logic                  drp_reset,     // Register bit only, no real MMCM
  output logic                  req,
  output logic                  we,
  output drp_addr_t             addr,
  output drp_word_t             wdata,
  input  logic                  ack,
  input  drp_word_t             rdata
);

  bridge_state_e state;
  logic          busy;
  logic          overrun;                      // Sticky, set by start while busy
  logic          start_wr;                     // DRP_ADDR write this cycle
  drp_word_t     data_buf;                     // Staging for write data bytes
  drp_word_t     rdata_q;                      // Last word read from DRP

  assign busy     = (state != BR_IDLE);
  assign req      = (state == BR_REQ);
  assign start_wr = reg_write && (reg_address == `REG_DRP_ADDR);

  // Bus read mux, zero unless one of our registers is addressed
  always_comb begin
    reg_datao = '0;
    if (reg_read) begin
      case (reg_address)
        `REG_DRP_ADDR:   reg_datao = {1'b0, addr};           // Bit 7 always reads 0
        `REG_DRP_DATA:   reg_datao = reg_bytecnt[0] ? rdata_q[15:8] : rdata_q[7:0];
        `REG_DRP_RESET:  reg_datao = {7'd0, drp_reset};
        `REG_DRP_STATUS: reg_datao = {6'd0, overrun, busy};
        default:         reg_datao = '0;
      endcase
    end
  end

  // Control state
  always_ff @(posedge clk_usb) begin
    if (reset_i) begin
      state     <= BR_IDLE;
      overrun   <= 1'b0;
      drp_reset <= 1'b0;
    end else begin
      if (reg_write && (reg_address == `REG_DRP_RESET))
        drp_reset <= reg_datai[0];
      if (reg_write && (reg_address == `REG_DRP_STATUS) && reg_datai[1])
        overrun <= 1'b0;                                     // Write 1 to clear
      if (start_wr && busy)
        overrun <= 1'b1;                                     // Start dropped
      case (state)
        BR_IDLE: if (start_wr) state <= BR_REQ;
        BR_REQ:  if (ack) state <= BR_DONE;                  // Req falls next
        BR_DONE: if (!ack) state <= BR_IDLE;                 // Four-phase closed
        default: state <= BR_IDLE;
      endcase
    end
  end

  // Payload, held stable from start to ack
  always_ff @(posedge clk_usb) begin
    if (reg_write && (reg_address == `REG_DRP_DATA)) begin
      if (reg_bytecnt[0])
        data_buf[15:8] <= reg_datai;                         // High byte
      else
        data_buf[7:0]  <= reg_datai;                         // Low byte
    end
    if (start_wr && !busy) begin
      addr  <= reg_datai[6:0];
      we    <= reg_datai[7];                                 // MSB selects write
      wdata <= data_buf;
    end
    if (req && ack && !we)
      rdata_q <= rdata;                                      // Keep read result
  end

endmodule

/* src/drp_phase_stepper.sv */
`include "drp_macros.svh"
`timescale 1ns/1ps

module drp_phase_stepper import drp_pkg::*; (
  input  logic                  clk_usb,
  input  logic                  reset_i,
  input  reg_byte_t             reg_address,
  input  logic [`BYTECNT_W-1:0] reg_bytecnt,
  input  reg_byte_t             reg_datai,
  input  logic                  reg_write,
  input  logic                  reg_read,
  output reg_byte_t             reg_datao,
  output logic                  req,
  output logic                  we,
  output drp_addr_t             addr,
  output drp_word_t             wdata,
  input  logic                  ack,
  input  drp_word_t             rdata
);

  step_state_e state;
  logic        busy;
  logic        overrun;
  logic        ctrl_wr;
  drp_addr_t   step_addr;                      // Programmed target
  reg_byte_t   step_delta;                     // Signed two's complement
  phase_t      new_phase;

  assign busy      = (state != ST_IDLE);
  assign req       = (state == ST_RD_REQ) || (state == ST_WR_REQ);
  assign we        = (state == ST_WR_REQ);
  assign ctrl_wr   = reg_write && (reg_address == `REG_STEP_CTRL);
  // Low 6 bits of the signed delta give the sum modulo 64
  assign new_phase = phase_t'(rdata[`PHASE_W-1:0] + step_delta[`PHASE_W-1:0]);

  // Single-byte registers answer at byte count 0 only
  always_comb begin
    reg_datao = '0;
    if (reg_read && (reg_bytecnt == '0)) begin
      case (reg_address)
        `REG_STEP_ADDR:  reg_datao = {1'b0, step_addr};
        `REG_STEP_DELTA: reg_datao = step_delta;
        `REG_STEP_CTRL:  reg_datao = {6'd0, overrun, busy};
        default:         reg_datao = '0;
      endcase
    end
  end

  always_ff @(posedge clk_usb) begin
    if (reset_i) begin
      state   <= ST_IDLE;
      overrun <= 1'b0;
    end else begin
      if (ctrl_wr && reg_datai[1])
        overrun <= 1'b0;                                     // Clear flag
      if (ctrl_wr && reg_datai[0] && busy)
        overrun <= 1'b1;                                     // Go ignored
      case (state)
        ST_IDLE:   if (ctrl_wr && reg_datai[0]) state <= ST_RD_REQ;
        ST_RD_REQ: if (ack) state <= ST_RD_REL;
        ST_RD_REL: if (!ack) state <= ST_WR_REQ;             // Re-request for write
        ST_WR_REQ: if (ack) state <= ST_WR_REL;
        ST_WR_REL: if (!ack) state <= ST_IDLE;
        default:   state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_usb) begin
    if (reg_write && (reg_address == `REG_STEP_ADDR))
      step_addr <= reg_datai[6:0];
    if (reg_write && (reg_address == `REG_STEP_DELTA))
      step_delta <= reg_datai;
    if (ctrl_wr && reg_datai[0] && !busy)
      addr <= step_addr;                                     // Frozen for both halves
    if ((state == ST_RD_REQ) && ack)
      wdata <= {rdata[`DRP_DATA_W-1:`PHASE_W], new_phase};   // Upper bits kept
  end

endmodule

/* src/drp_arbiter.sv */
`include "drp_macros.svh"
`timescale 1ns/1ps

module drp_arbiter import drp_pkg::*; (
  input  logic      clk_usb,
  input  logic      reset_i,
  input  logic      m0_req,
  input  logic      m0_we,
  input  drp_addr_t m0_addr,
  input  drp_word_t m0_wdata,
  output logic      m0_ack,
  output drp_word_t m0_rdata,
  input  logic      m1_req,
  input  logic      m1_we,
  input  drp_addr_t m1_addr,
  input  drp_word_t m1_wdata,
  output logic      m1_ack,
  output drp_word_t m1_rdata,
  output drp_addr_t drp_addr,
  output logic      drp_den,
  output logic      drp_dwe,
  output drp_word_t drp_din,
  input  drp_word_t drp_dout,
  input  logic      drp_drdy
);

  arb_state_e state;
  logic       grant;                           // 0 = m0, 1 = m1
  logic       last_served;
  logic       pick;                            // Winner if granted now
  logic       gnt_req;
  logic       we_q;
  drp_word_t  rdata_q;

  // Both asking: last served loses
  assign pick    = (m0_req && m1_req) ? ~last_served : m1_req;
  assign gnt_req = grant ? m1_req : m0_req;

  assign drp_den  = (state == AR_ISSUE);                     // One cycle by construction
  assign drp_dwe  = drp_den && we_q;
  assign m0_ack   = (state == AR_ACK) && !grant;
  assign m1_ack   = (state == AR_ACK) && grant;
  assign m0_rdata = rdata_q;
  assign m1_rdata = rdata_q;

  always_ff @(posedge clk_usb) begin
    if (reset_i) begin
      state       <= AR_IDLE;
      grant       <= 1'b0;
      last_served <= 1'b1;                                   // m0 wins first tie
    end else begin
      case (state)
        AR_IDLE: if (m0_req || m1_req) begin
          grant       <= pick;
          last_served <= pick;
          state       <= AR_ISSUE;
        end
        AR_ISSUE: state <= AR_WAIT;
        AR_WAIT:  if (drp_drdy) state <= AR_ACK;
        AR_ACK:   if (!gnt_req) state <= AR_IDLE;            // Master released
        default:  state <= AR_IDLE;
      endcase
    end
  end

  // Capture the winner's command while idle
  always_ff @(posedge clk_usb) begin
    if (state == AR_IDLE) begin
      we_q     <= pick ? m1_we : m0_we;
      drp_addr <= pick ? m1_addr : m0_addr;
      drp_din  <= pick ? m1_wdata : m0_wdata;
    end
    if ((state == AR_WAIT) && drp_drdy)
      rdata_q <= drp_dout;                                   // Valid with ack
  end

endmodule

/* src/mmcm_drp_target.sv */
`include "drp_macros.svh"
`timescale 1ns/1ps

module mmcm_drp_target import drp_pkg::*; (
  input  logic      clk_usb,
  input  logic      reset_i,
  input  drp_addr_t drp_addr,
  input  logic      drp_den,
  input  logic      drp_dwe,
  input  drp_word_t drp_din,
  output drp_word_t drp_dout,
  output logic      drp_drdy
);

  drp_word_t  mem [0:(1 << `DRP_ADDR_W)-1];    // Stand-in config memory
  drp_addr_t  addr_q;
  logic       pend;                            // Access in flight
  logic [3:0] cnt;
  logic       fire;

  assign fire = pend && (cnt == 4'd1);         // drdy due next cycle

  initial begin
    for (int i = 0; i < (1 << `DRP_ADDR_W); i++)
      mem[i] = '0;
  end

  always_ff @(posedge clk_usb) begin
    if (reset_i) begin
      pend     <= 1'b0;
      cnt      <= '0;
      drp_drdy <= 1'b0;
    end else begin
      drp_drdy <= fire;                                      // One-cycle strobe
      if (drp_den) begin
        pend <= 1'b1;
        cnt  <= 4'(`DRDY_LATENCY - 1);
      end else if (pend) begin
        cnt <= cnt - 4'd1;
        if (fire)
          pend <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_usb) begin
    if (drp_den) begin
      addr_q <= drp_addr;
      if (drp_dwe)
        mem[drp_addr] <= drp_din;                            // Write at den
    end
    if (fire)
      drp_dout <= mem[addr_q];                               // Registered with drdy
  end

endmodule

/* src/clk_reconfig_top.sv */
`include "drp_macros.svh"
`timescale 1ns/1ps

module clk_reconfig_top import drp_pkg::*; (
  input  logic                  clk_usb,
  input  logic                  reset_i,
  input  reg_byte_t             reg_address,
  input  logic [`BYTECNT_W-1:0] reg_bytecnt,
  input  reg_byte_t             reg_datai,
  input  logic                  reg_write,
  input  logic                  reg_read,
  output reg_byte_t             reg_datao,
  output logic                  drp_reset
);

  reg_byte_t bridge_datao, step_datao;
  logic      m0_req, m0_we, m0_ack;
  logic      m1_req, m1_we, m1_ack;
  drp_addr_t m0_addr, m1_addr, drp_addr;
  drp_word_t m0_wdata, m0_rdata, m1_wdata, m1_rdata;
  logic      drp_den, drp_dwe, drp_drdy;
  drp_word_t drp_din, drp_dout;

  assign reg_datao = bridge_datao | step_datao;              // Each block zeroes when idle

  reg_drp_bridge u_bridge (
    .clk_usb, .reset_i, .reg_address, .reg_bytecnt, .reg_datai, .reg_write, .reg_read,
    .reg_datao(bridge_datao), .drp_reset,
    .req(m0_req), .we(m0_we), .addr(m0_addr), .wdata(m0_wdata),
    .ack(m0_ack), .rdata(m0_rdata)
  );

  drp_phase_stepper u_stepper (
    .clk_usb, .reset_i, .reg_address, .reg_bytecnt, .reg_datai, .reg_write, .reg_read,
    .reg_datao(step_datao),
    .req(m1_req), .we(m1_we), .addr(m1_addr), .wdata(m1_wdata),
    .ack(m1_ack), .rdata(m1_rdata)
  );

  drp_arbiter u_arbiter (
    .clk_usb, .reset_i,
    .m0_req, .m0_we, .m0_addr, .m0_wdata, .m0_ack, .m0_rdata,
    .m1_req, .m1_we, .m1_addr, .m1_wdata, .m1_ack, .m1_rdata,
    .drp_addr, .drp_den, .drp_dwe, .drp_din, .drp_dout, .drp_drdy
  );

  mmcm_drp_target u_target (
    .clk_usb, .reset_i,
    .drp_addr, .drp_den, .drp_dwe, .drp_din, .drp_dout, .drp_drdy
  );

endmodule

/* verif/clk_reconfig_properties.sv */
`include "drp_macros.svh"
`timescale 1ns/1ps

module clk_reconfig_properties (
  input logic clk_usb,
  input logic reset_i,
  input logic m0_req,
  input logic m0_ack,
  input logic m1_req,
  input logic m1_ack,
  input logic drp_den,
  input logic drp_drdy
);

  int fail_count = 0;                          // Read by the testbench

  // Ack only answers a live request
  ack0_needs_req: assert property (@(posedge clk_usb) disable iff (reset_i)
    $rose(m0_ack) |-> m0_req)
    else begin
      fail_count++;
      $error("m0_ack rose without m0_req");
    end
  ack1_needs_req: assert property (@(posedge clk_usb) disable iff (reset_i)
    $rose(m1_ack) |-> m1_req)
    else begin
      fail_count++;
      $error("m1_ack rose without m1_req");
    end

  // Single den pulse answered by drdy after the fixed latency
  den_one_cycle: assert property (@(posedge clk_usb) disable iff (reset_i)
    drp_den |=> !drp_den ##(`DRDY_LATENCY - 1) drp_drdy)
    else begin
      fail_count++;
      $error("drp_den not a single pulse answered by drp_drdy");
    end

  acks_exclusive: assert property (@(posedge clk_usb) disable iff (reset_i)
    !(m0_ack && m1_ack))
    else begin
      fail_count++;
      $error("both acks high together");
    end

  // Four-phase rule holds req until ack arrives
  req0_held: assert property (@(posedge clk_usb) disable iff (reset_i)
    (m0_req && !m0_ack) |=> m0_req)
    else begin
      fail_count++;
      $error("m0_req dropped before m0_ack");
    end
  req1_held: assert property (@(posedge clk_usb) disable iff (reset_i)
    (m1_req && !m1_ack) |=> m1_req)
    else begin
      fail_count++;
      $error("m1_req dropped before m1_ack");
    end

endmodule

bind drp_arbiter clk_reconfig_properties u_props (
  .clk_usb, .reset_i, .m0_req, .m0_ack, .m1_req, .m1_ack, .drp_den, .drp_drdy
);

/* verif/clk_reconfig_tb.sv */
`include "drp_macros.svh"
`timescale 1ns/1ps

module clk_reconfig_tb import drp_pkg::*; ();

  localparam int CYCLE_LIMIT = 4000;           // 6 tests x worst-case status polling

  logic                  clk_usb = 1'b0;
  logic                  reset_i;
  reg_byte_t             reg_address;
  logic [`BYTECNT_W-1:0] reg_bytecnt;
  reg_byte_t             reg_datai;
  logic                  reg_write;
  logic                  reg_read;
  reg_byte_t             reg_datao;
  logic                  drp_reset;
  logic [31:0]           lfsr_state = 32'h8dab3747;
  drp_word_t             exp_mem [0:127];      // Reference view of the DRP memory
  int                    cycle_count;

  clk_reconfig_top uut (
    .clk_usb, .reset_i, .reg_address, .reg_bytecnt, .reg_datai,
    .reg_write, .reg_read, .reg_datao, .drp_reset
  );

  always #20 clk_usb = ~clk_usb;               // 40 ns period

  // Galois LFSR stepped once per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      val = {val[30:0], lfsr_state[0]};
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'hA300_0000) : (lfsr_state >> 1);
    end
    return val;
  endfunction

  // Phase field plus signed delta wrapped into 0..63
  function automatic drp_word_t stepped(input drp_word_t w, input reg_byte_t delta);
    int p;
    p = int'(w[5:0]) + int'($signed(delta));
    p = ((p % 64) + 64) % 64;
    return {w[15:6], p[5:0]};
  endfunction

  task automatic check(input logic [31:0] expected, input logic [31:0] actual,
                       input string what);
    if (expected !== actual) begin
      $display("[FAIL] %0t ns: %s, expected %h, got %h", $time, what, expected, actual);
      $display("TEST RESULT: FAIL");
      $fatal(1, "Value mismatch");
    end
  endtask

  // Bus tasks start and end 2 ns after a rising edge
  task automatic bus_write(input reg_byte_t a, input logic [`BYTECNT_W-1:0] cnt,
                           input reg_byte_t d);
    reg_address = a;
    reg_bytecnt = cnt;
    reg_datai   = d;
    reg_write   = 1'b1;
    @(posedge clk_usb);                        // Taken on this edge
    #2 reg_write = 1'b0;
  endtask

  task automatic bus_read(input reg_byte_t a, input logic [`BYTECNT_W-1:0] cnt,
                          output reg_byte_t d);
    reg_address = a;
    reg_bytecnt = cnt;
    reg_read    = 1'b1;
    #10 d = reg_datao;                         // Mid-cycle once the combinational path settles
    @(posedge clk_usb);
    #2 reg_read = 1'b0;
  endtask

  task automatic wait_idle(input reg_byte_t status_addr);
    reg_byte_t st;
    st = 8'h01;
    while (st[0])
      bus_read(status_addr, 7'd0, st);         // Poll busy bit
  endtask

  task automatic load_data(input drp_word_t w);
    bus_write(`REG_DRP_DATA, 7'd0, w[7:0]);
    bus_write(`REG_DRP_DATA, 7'd1, w[15:8]);
  endtask

  task automatic drp_write(input drp_addr_t a, input drp_word_t w);
    load_data(w);
    bus_write(`REG_DRP_ADDR, 7'd0, {1'b1, a}); // Bit 7 set for write
    exp_mem[a] = w;
    wait_idle(`REG_DRP_STATUS);
  endtask

  task automatic drp_read(input drp_addr_t a, output drp_word_t w);
    reg_byte_t lo, hi;
    bus_write(`REG_DRP_ADDR, 7'd0, {1'b0, a});
    wait_idle(`REG_DRP_STATUS);
    bus_read(`REG_DRP_DATA, 7'd0, lo);
    bus_read(`REG_DRP_DATA, 7'd1, hi);
    w = {hi, lo};
  endtask

  task automatic verify_word(input drp_addr_t a, input string what);
    drp_word_t w;
    drp_read(a, w);
    check(32'(exp_mem[a]), 32'(w), what);
  endtask

  task automatic phase_step(input drp_addr_t a, input reg_byte_t delta);
    bus_write(`REG_STEP_ADDR, 7'd0, {1'b0, a});
    bus_write(`REG_STEP_DELTA, 7'd0, delta);
    bus_write(`REG_STEP_CTRL, 7'd0, 8'h01);
    exp_mem[a] = stepped(exp_mem[a], delta);
    wait_idle(`REG_STEP_CTRL);
  endtask

  task automatic test_reset_state();
    reg_byte_t d;
    bus_read(`REG_DRP_STATUS, 7'd0, d);
    check(32'h0, 32'(d), "bridge status after reset");
    bus_read(`REG_STEP_CTRL, 7'd0, d);
    check(32'h0, 32'(d), "stepper status after reset");
    bus_read(`REG_DRP_RESET, 7'd0, d);
    check(32'h0, 32'(d), "DRP_RESET after reset");
  endtask

  task automatic test_write_read();
    drp_addr_t a;
    drp_word_t w;
    reg_byte_t d;
    for (int i = 0; i < 6; i++) begin
      a = drp_addr_t'(rand_bits(7));
      w = drp_word_t'(rand_bits(16));
      drp_write(a, w);
      bus_read(`REG_DRP_ADDR, 7'd0, d);        // Command had bit 7 set
      check(32'(a), 32'(d), "DRP_ADDR read back");
      verify_word(a, "bridge read back");
    end
  endtask

  task automatic test_drp_reset();
    reg_byte_t d;
    bus_write(`REG_DRP_RESET, 7'd0, 8'h01);
    bus_read(`REG_DRP_RESET, 7'd0, d);
    check(32'h1, 32'(d), "DRP_RESET set");
    check(32'h1, 32'(drp_reset), "drp_reset pin set");
    bus_write(`REG_DRP_RESET, 7'd0, 8'h00);
    bus_read(`REG_DRP_RESET, 7'd0, d);
    check(32'h0, 32'(d), "DRP_RESET cleared");
  endtask

  task automatic test_phase_step();
    drp_word_t w;
    w = drp_word_t'(rand_bits(16));
    w[5:0] = 6'h30;                            // 48 + 23 wraps to 7 and 7 - 45 wraps to 26
    drp_write(7'h15, w);
    phase_step(7'h15, 8'd23);
    verify_word(7'h15, "phase step +23");
    phase_step(7'h15, 8'hD3);                  // -45
    verify_word(7'h15, "phase step -45");
  endtask

  task automatic test_contention();
    drp_word_t wa;
    reg_byte_t d;
    drp_write(7'h21, drp_word_t'(rand_bits(16)));
    wa = drp_word_t'(rand_bits(16));
    bus_write(`REG_STEP_ADDR, 7'd0, 8'h21);
    bus_write(`REG_STEP_DELTA, 7'd0, 8'd5);
    load_data(wa);
    bus_write(`REG_DRP_ADDR, 7'd0, 8'hA0);     // Bridge write to 0x20
    bus_write(`REG_STEP_CTRL, 7'd0, 8'h01);    // Stepper go next cycle
    exp_mem[7'h20] = wa;
    exp_mem[7'h21] = stepped(exp_mem[7'h21], 8'd5);
    wait_idle(`REG_DRP_STATUS);
    wait_idle(`REG_STEP_CTRL);
    bus_read(`REG_DRP_STATUS, 7'd0, d);
    check(32'h0, 32'(d), "bridge status after contention");
    bus_read(`REG_STEP_CTRL, 7'd0, d);
    check(32'h0, 32'(d), "stepper status after contention");
    verify_word(7'h20, "bridge word after contention");
    verify_word(7'h21, "stepped word after contention");
  endtask

  task automatic test_overrun();
    drp_word_t wa;
    reg_byte_t d;
    wa = drp_word_t'(rand_bits(16));
    drp_write(7'h31, ~wa);                     // Known old value at the dropped address
    load_data(wa);
    bus_write(`REG_DRP_ADDR, 7'd0, 8'hB0);
    bus_write(`REG_DRP_ADDR, 7'd0, 8'hB1);     // Lands while busy
    exp_mem[7'h30] = wa;
    wait_idle(`REG_DRP_STATUS);
    bus_read(`REG_DRP_STATUS, 7'd0, d);
    check(32'h2, 32'(d), "overrun flag set");
    bus_write(`REG_DRP_STATUS, 7'd0, 8'h02);
    bus_read(`REG_DRP_STATUS, 7'd0, d);
    check(32'h0, 32'(d), "overrun flag cleared");
    verify_word(7'h30, "first write performed");
    verify_word(7'h31, "dropped write not performed");
  endtask

  initial begin
    cycle_count = 0;
    while (cycle_count < CYCLE_LIMIT) begin
      @(posedge clk_usb);
      cycle_count++;
      if (uut.u_arbiter.u_props.fail_count != 0) begin
        $display("Arbiter handshake property failed at %0t ns", $time);
        $display("TEST RESULT: FAIL");
        $fatal(1, "Property failure");
      end
    end
    $display("Timeout: run exceeded %0d clock cycles", CYCLE_LIMIT);
    $display("TEST RESULT: FAIL");
    $fatal(1, "Timeout");
  end

  initial begin
    reset_i     = 1'b1;
    reg_address = '0;
    reg_bytecnt = '0;
    reg_datai   = '0;
    reg_write   = 1'b0;
    reg_read    = 1'b0;
    for (int i = 0; i < 128; i++)
      exp_mem[i] = '0;                         // Target memory starts cleared
    repeat (3) @(posedge clk_usb);
    #2 reset_i = 1'b0;
    test_reset_state();
    test_write_read();
    test_drp_reset();
    test_phase_step();
    test_contention();
    test_overrun();
    if (uut.u_arbiter.u_props.fail_count == 0) begin
      $display("TEST RESULT: PASS");
      $finish;
    end else begin
      $display("Arbiter handshake property failed during the run");
      $display("TEST RESULT: FAIL");
      $fatal(1, "Property failure");
    end
  end

endmodule

/* compile.f */
+incdir+src
src/drp_pkg.sv
src/reg_drp_bridge.sv
src/drp_phase_stepper.sv
src/drp_arbiter.sv
src/mmcm_drp_target.sv
src/clk_reconfig_top.sv
verif/clk_reconfig_properties.sv
verif/clk_reconfig_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the clock-reconfiguration testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ps \
  --top-module clk_reconfig_tb -f compile.f -o clk_reconfig_sim
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit "$status"
fi

./obj_dir/clk_reconfig_sim
status=$?
if [ "$status" -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit "$status"
fi

echo "Simulation completed"
exit 0
